/* Bender.yml */
package:
  name: alu_iq

sources:
  - files:
      - hw/alu_iq_pkg.sv
      - hw/iq_entry.sv
      - hw/alu_exec.sv
      - hw/alu_iq.sv
  - target: simulation
    files:
      - sim/alu_iq_properties.sv
      - sim/alu_iq_tb.sv

/* hw/alu_exec.sv */
`default_nettype none

module alu_exec (
    input  alu_iq_pkg::decode_info_t di_i,
    input  alu_iq_pkg::word_t        op_a_i,
    input  alu_iq_pkg::word_t        op_b_i,
    output alu_iq_pkg::word_t        result_o,
    output logic                     taken_o,
    output alu_iq_pkg::word_t        target_o
);

    import alu_iq_pkg::*;

    word_t      opnd_b;
    word_t      branch_tgt;
    word_t      link_addr;
    logic [4:0] shamt;

    // immediate only replaces the alu operand, branches compare registers
    assign opnd_b     = di_i.use_imm ? di_i.imm : op_b_i;
    assign shamt      = opnd_b[4:0];
    assign branch_tgt = di_i.pc + di_i.imm;
    assign link_addr  = di_i.pc + WORD_W'(4);

    always_comb begin
        result_o = '0;
        taken_o  = 1'b0;
        target_o = '0;
        case (di_i.op)
            // --------------------------------------------------
            // alu ops
            // --------------------------------------------------
            OP_ADD: result_o = op_a_i + opnd_b;
            OP_SUB: result_o = op_a_i - opnd_b;
            OP_AND: result_o = op_a_i & opnd_b;
            OP_OR:  result_o = op_a_i | opnd_b;
            OP_XOR: result_o = op_a_i ^ opnd_b;
            OP_SLL: result_o = op_a_i << shamt;
            OP_SRL: result_o = op_a_i >> shamt;
            OP_SLT: begin
                result_o = {{(WORD_W-1){1'b0}}, ($signed(op_a_i) < $signed(opnd_b))};
            end
            // --------------------------------------------------
            // branch ops
            // --------------------------------------------------
            OP_BEQ: begin
                taken_o  = (op_a_i == op_b_i);
                target_o = branch_tgt;
            end
            OP_BNE: begin
                taken_o  = (op_a_i != op_b_i);
                target_o = branch_tgt;
            end
            OP_BLT: begin
                taken_o  = ($signed(op_a_i) < $signed(op_b_i));
                target_o = branch_tgt;
            end
            // unconditional, writes the return address
            OP_JAL: begin
                taken_o  = 1'b1;
                target_o = branch_tgt;
                result_o = link_addr;
            end
            default: begin
                result_o = '0;
                taken_o  = 1'b0;
                target_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/alu_iq.sv */
`default_nettype none

module alu_iq (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  logic                                        flush_i,

    // dispatch
    input  logic [alu_iq_pkg::DISPATCH_CNT-1:0]         choose_i,
    input  logic [alu_iq_pkg::DISPATCH_CNT-1:0]         disp_valid_i,
    input  alu_iq_pkg::decode_info_t [alu_iq_pkg::DISPATCH_CNT-1:0] disp_di_i,
    input  alu_iq_pkg::word_t
           [alu_iq_pkg::DISPATCH_CNT-1:0][alu_iq_pkg::SRC_CNT-1:0] disp_src_data_i,
    input  alu_iq_pkg::rob_id_t
           [alu_iq_pkg::DISPATCH_CNT-1:0][alu_iq_pkg::SRC_CNT-1:0] disp_src_tag_i,
    input  logic
           [alu_iq_pkg::DISPATCH_CNT-1:0][alu_iq_pkg::SRC_CNT-1:0] disp_src_ready_i,
    output logic                                        disp_ready_o,

    // common data bus
    input  logic                [alu_iq_pkg::CDB_CNT-1:0] cdb_valid_i,
    input  alu_iq_pkg::rob_id_t [alu_iq_pkg::CDB_CNT-1:0] cdb_tag_i,
    input  alu_iq_pkg::word_t   [alu_iq_pkg::CDB_CNT-1:0] cdb_data_i,

    // early wakeup
    output logic                                        wkup_valid_o,
    output alu_iq_pkg::rob_id_t                         wkup_tag_o,

    // result stage
    input  logic                                        out_ready_i,
    output logic                                        result_valid_o,
    output alu_iq_pkg::rob_id_t                         result_tag_o,
    output alu_iq_pkg::word_t                           result_o,
    output logic                                        taken_o,
    output alu_iq_pkg::word_t                           target_o
);

    import alu_iq_pkg::*;

    // --------------------------------------------------
    // dispatch port choice
    // --------------------------------------------------
    logic                    disp_sel_valid;
    decode_info_t            disp_di;
    word_t   [SRC_CNT-1:0]   disp_data;
    rob_id_t [SRC_CNT-1:0]   disp_tag;
    logic    [SRC_CNT-1:0]   disp_rdy;
    logic                    disp_fire;

    // choose_i is one-hot
    always_comb begin
        disp_sel_valid = 1'b0;
        disp_di        = '0;
        disp_data      = '0;
        disp_tag       = '0;
        disp_rdy       = '0;
        for (int p = 0; p < DISPATCH_CNT; p++) begin
            if (choose_i[p]) begin
                disp_sel_valid = disp_valid_i[p];
                disp_di        = disp_di_i[p];
                disp_data      = disp_src_data_i[p];
                disp_tag       = disp_src_tag_i[p];
                disp_rdy       = disp_src_ready_i[p];
            end
        end
    end

    // --------------------------------------------------
    // slot allocation
    // --------------------------------------------------
    logic         [IQ_SIZE-1:0]              busy;
    logic         [IQ_SIZE-1:0]              eligible;
    logic         [IQ_SIZE-1:0][AGE_W-1:0]   age;
    decode_info_t [IQ_SIZE-1:0]              ent_di;
    word_t        [IQ_SIZE-1:0][SRC_CNT-1:0] ent_data;
    logic         [IQ_SIZE-1:0]              alloc_vec;
    logic         [IQ_SIZE-1:0]              issue_vec;
    logic                                    free_found;

    assign disp_ready_o = ~(&busy);
    assign disp_fire    = disp_sel_valid & disp_ready_o & ~flush_i;

    // lowest free slot takes the instruction
    always_comb begin
        alloc_vec  = '0;
        free_found = 1'b0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (!free_found && !busy[i]) begin
                alloc_vec[i] = disp_fire;
                free_found   = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // age select
    // --------------------------------------------------
    logic [IQ_IDX_W-1:0] sel_idx;
    logic [AGE_W-1:0]    sel_age;
    logic                any_eligible;
    logic                result_valid_q;
    logic                stage_free;
    logic                issue_fire;

    // strict compare keeps the lower index on a tie
    always_comb begin
        sel_idx      = '0;
        sel_age      = '0;
        any_eligible = 1'b0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (eligible[i] && (!any_eligible || (age[i] > sel_age))) begin
                sel_idx      = IQ_IDX_W'(i);
                sel_age      = age[i];
                any_eligible = 1'b1;
            end
        end
    end

    assign stage_free = ~result_valid_q | out_ready_i;
    assign issue_fire = any_eligible & stage_free & ~flush_i;

    always_comb begin
        issue_vec          = '0;
        issue_vec[sel_idx] = issue_fire;
    end

    // tag goes out the cycle before its result appears
    assign wkup_valid_o = issue_fire;
    assign wkup_tag_o   = ent_di[sel_idx].dest_id;

    // --------------------------------------------------
    // queue slots
    // --------------------------------------------------
    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        iq_entry u_entry (
            .clk         (clk),
            .reset_i     (reset_i),
            .flush_i     (flush_i),
            .alloc_i     (alloc_vec[i]),
            .issue_i     (issue_vec[i]),
            .di_i        (disp_di),
            .src_data_i  (disp_data),
            .src_tag_i   (disp_tag),
            .src_ready_i (disp_rdy),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .cdb_data_i  (cdb_data_i),
            .busy_o      (busy[i]),
            .eligible_o  (eligible[i]),
            .age_o       (age[i]),
            .di_o        (ent_di[i]),
            .src_data_o  (ent_data[i])
        );
    end

    // --------------------------------------------------
    // issue register and result stage
    // --------------------------------------------------
    decode_info_t ex_di_q;
    word_t        ex_a_q;
    word_t        ex_b_q;

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            ex_di_q <= ent_di[sel_idx];
            ex_a_q  <= ent_data[sel_idx][0];
            ex_b_q  <= ent_data[sel_idx][1];
        end
    end

    // held until the consumer takes it
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            result_valid_q <= 1'b0;
        end else if (issue_fire) begin
            result_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            result_valid_q <= 1'b0;
        end
    end

    alu_exec u_exec (
        .di_i     (ex_di_q),
        .op_a_i   (ex_a_q),
        .op_b_i   (ex_b_q),
        .result_o (result_o),
        .taken_o  (taken_o),
        .target_o (target_o)
    );

    assign result_valid_o = result_valid_q;
    assign result_tag_o   = ex_di_q.dest_id;

endmodule

`default_nettype wire

/* hw/alu_iq_pkg.sv */
`default_nettype none

package alu_iq_pkg;

    // --------------------------------------------------
    // sizes and counts
    // --------------------------------------------------
    localparam int WORD_W       = 32;
    localparam int ROB_ID_W     = 4;
    localparam int IQ_SIZE      = 4;
    // index width for one slot of the queue
    localparam int IQ_IDX_W     = $clog2(IQ_SIZE);
    localparam int AGE_W        = 3;
    localparam int DISPATCH_CNT = 2;
    localparam int CDB_CNT      = 2;
    localparam int SRC_CNT      = 2;

    // --------------------------------------------------
    // basic data types
    // --------------------------------------------------
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // --------------------------------------------------
    // opcodes
    // --------------------------------------------------
    typedef enum logic [3:0] {
        // alu group
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_AND = 4'h2,
        OP_OR  = 4'h3,
        OP_XOR = 4'h4,
        // shift amount from the low 5 bits
        OP_SLL = 4'h5,
        OP_SRL = 4'h6,
        // signed less-than
        OP_SLT = 4'h7,
        // branch group
        OP_BEQ = 4'h8,
        OP_BNE = 4'h9,
        OP_BLT = 4'hA,
        // link value is pc + 4
        OP_JAL = 4'hB
    } alu_op_e;

    // --------------------------------------------------
    // decoded instruction as it sits in a slot
    // --------------------------------------------------
    typedef struct packed {
        alu_op_e op;
        // immediate replaces the second operand for alu ops
        logic    use_imm;
        word_t   pc;
        word_t   imm;
        // tag broadcast with the result
        rob_id_t dest_id;
    } decode_info_t;

endpackage

`default_nettype wire

/* hw/iq_entry.sv */
`default_nettype none

module iq_entry (
    input  logic                                               clk,
    input  logic                                               reset_i,
    input  logic                                               flush_i,
    input  logic                                               alloc_i,
    input  logic                                               issue_i,
    input  alu_iq_pkg::decode_info_t                           di_i,
    input  alu_iq_pkg::word_t   [alu_iq_pkg::SRC_CNT-1:0]      src_data_i,
    input  alu_iq_pkg::rob_id_t [alu_iq_pkg::SRC_CNT-1:0]      src_tag_i,
    input  logic                [alu_iq_pkg::SRC_CNT-1:0]      src_ready_i,
    input  logic                [alu_iq_pkg::CDB_CNT-1:0]      cdb_valid_i,
    input  alu_iq_pkg::rob_id_t [alu_iq_pkg::CDB_CNT-1:0]      cdb_tag_i,
    input  alu_iq_pkg::word_t   [alu_iq_pkg::CDB_CNT-1:0]      cdb_data_i,
    output logic                                               busy_o,
    output logic                                               eligible_o,
    output logic                [alu_iq_pkg::AGE_W-1:0]        age_o,
    output alu_iq_pkg::decode_info_t                           di_o,
    output alu_iq_pkg::word_t   [alu_iq_pkg::SRC_CNT-1:0]      src_data_o
);

    import alu_iq_pkg::*;

    logic                    busy_q;
    logic    [SRC_CNT-1:0]   rdy_q;
    logic    [AGE_W-1:0]     age_q;
    rob_id_t [SRC_CNT-1:0]   tag_q;
    word_t   [SRC_CNT-1:0]   data_q;
    decode_info_t            di_q;

    rob_id_t [SRC_CNT-1:0]   snoop_tag;
    logic    [SRC_CNT-1:0]   cdb_hit;
    word_t   [SRC_CNT-1:0]   cdb_word;

    // --------------------------------------------------
    // cdb snoop
    // --------------------------------------------------
    // on alloc the incoming tag is compared, so a broadcast in the
    // dispatch cycle is not missed
    always_comb begin
        for (int s = 0; s < SRC_CNT; s++) begin
            snoop_tag[s] = alloc_i ? src_tag_i[s] : tag_q[s];
            cdb_hit[s]   = 1'b0;
            cdb_word[s]  = '0;
            // lowest matching port wins
            for (int c = 0; c < CDB_CNT; c++) begin
                if (!cdb_hit[s] && cdb_valid_i[c] && (cdb_tag_i[c] == snoop_tag[s])) begin
                    cdb_hit[s]  = 1'b1;
                    cdb_word[s] = cdb_data_i[c];
                end
            end
        end
    end

    // --------------------------------------------------
    // slot control
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            busy_q <= 1'b0;
            rdy_q  <= '0;
            age_q  <= '0;
        end else begin
            if (alloc_i) begin
                busy_q <= 1'b1;
            end else if (issue_i) begin
                busy_q <= 1'b0;
            end
            for (int s = 0; s < SRC_CNT; s++) begin
                if (alloc_i) begin
                    rdy_q[s] <= src_ready_i[s] | cdb_hit[s];
                end else if (busy_q && cdb_hit[s]) begin
                    rdy_q[s] <= 1'b1;
                end
            end
            // saturating age, only while waiting to issue
            if (eligible_o && !issue_i) begin
                if (age_q != '1) begin
                    age_q <= age_q + AGE_W'(1);
                end
            end else begin
                age_q <= '0;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            di_q <= di_i;
            for (int s = 0; s < SRC_CNT; s++) begin
                tag_q[s]  <= src_tag_i[s];
                data_q[s] <= src_ready_i[s] ? src_data_i[s] : cdb_word[s];
            end
        end else begin
            for (int s = 0; s < SRC_CNT; s++) begin
                if (busy_q && !rdy_q[s] && cdb_hit[s]) begin
                    data_q[s] <= cdb_word[s];
                end
            end
        end
    end

    assign busy_o     = busy_q;
    assign eligible_o = busy_q & (&rdy_q);
    assign age_o      = age_q;
    assign di_o       = di_q;
    assign src_data_o = data_q;

endmodule

`default_nettype wire

/* sim/alu_iq_properties.sv */
`default_nettype none

module alu_iq_properties (
    input logic                                 clk,
    input logic                                 reset_i,
    input logic                                 flush_i,
    input logic                                 out_ready_i,
    input logic [alu_iq_pkg::DISPATCH_CNT-1:0]  choose_i,
    input logic [alu_iq_pkg::DISPATCH_CNT-1:0]  disp_valid_i,
    input logic                                 disp_ready_i,
    input logic                                 wkup_valid_i,
    input alu_iq_pkg::rob_id_t                  wkup_tag_i,
    input logic                                 result_valid_i,
    input alu_iq_pkg::rob_id_t                  result_tag_i,
    input alu_iq_pkg::word_t                    result_i,
    input logic                                 taken_i,
    input alu_iq_pkg::word_t                    target_i
);

    timeunit 1ns;
    timeprecision 100ps;

    import alu_iq_pkg::*;

    int unsigned fails = 0;

    // slots taken, counted from the handshakes at the ports
    int          occupancy;
    logic        disp_accept;

    assign disp_accept = (|(choose_i & disp_valid_i)) && disp_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + (disp_accept ? 1 : 0) - (wkup_valid_i ? 1 : 0);
        end
    end

    // announced tag shows up on the result one cycle later
    wkup_then_result: assert property (@(posedge clk) disable iff (reset_i)
        wkup_valid_i |=> result_valid_i && (result_tag_i == $past(wkup_tag_i))
    ) else begin
        $error("wakeup tag not followed by a matching result");
        fails++;
    end

    // held result must not move under backpressure
    result_held: assert property (@(posedge clk) disable iff (reset_i)
        result_valid_i && !out_ready_i && !flush_i |=>
            result_valid_i && $stable(result_tag_i) && $stable(result_i) &&
            $stable(taken_i) && $stable(target_i)
    ) else begin
        $error("result changed while stalled");
        fails++;
    end

    full_not_ready: assert property (@(posedge clk) disable iff (reset_i)
        (occupancy == IQ_SIZE) && !wkup_valid_i |-> !disp_ready_i
    ) else begin
        $error("dispatch ready with all slots busy");
        fails++;
    end

endmodule

`default_nettype wire

/* sim/alu_iq_tb.sv */
`default_nettype none

module alu_iq_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import alu_iq_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int TAG_CNT = 2**ROB_ID_W;

    logic                                    clk;
    logic                                    reset_i;
    logic                                    flush_i;
    logic    [DISPATCH_CNT-1:0]              choose_i;
    logic    [DISPATCH_CNT-1:0]              disp_valid_i;
    decode_info_t [DISPATCH_CNT-1:0]         disp_di_i;
    word_t   [DISPATCH_CNT-1:0][SRC_CNT-1:0] disp_src_data_i;
    rob_id_t [DISPATCH_CNT-1:0][SRC_CNT-1:0] disp_src_tag_i;
    logic    [DISPATCH_CNT-1:0][SRC_CNT-1:0] disp_src_ready_i;
    logic                                    disp_ready_o;
    logic    [CDB_CNT-1:0]                   cdb_valid_i;
    rob_id_t [CDB_CNT-1:0]                   cdb_tag_i;
    word_t   [CDB_CNT-1:0]                   cdb_data_i;
    logic                                    wkup_valid_o;
    rob_id_t                                 wkup_tag_o;
    logic                                    out_ready_i;
    logic                                    result_valid_o;
    rob_id_t                                 result_tag_o;
    word_t                                   result_o;
    logic                                    taken_o;
    word_t                                   target_o;

    // scoreboard keyed by dest_id
    logic         exp_live [TAG_CNT];
    decode_info_t exp_di   [TAG_CNT];
    word_t        exp_a    [TAG_CNT];
    word_t        exp_b    [TAG_CNT];
    int           pending;
    int           errors;
    int           results;
    int           tests_run;
    logic         timed_out;
    logic [31:0]  lcg_state;
    rob_id_t      next_tag;

    alu_iq dut0 (.*);

    bind alu_iq alu_iq_properties u_props (
        .clk(clk), .reset_i(reset_i), .flush_i(flush_i), .out_ready_i(out_ready_i),
        .choose_i(choose_i), .disp_valid_i(disp_valid_i), .disp_ready_i(disp_ready_o),
        .wkup_valid_i(wkup_valid_o), .wkup_tag_i(wkup_tag_o),
        .result_valid_i(result_valid_o), .result_tag_i(result_tag_o),
        .result_i(result_o), .taken_i(taken_o), .target_i(target_o)
    );

    always #4 clk = ~clk;

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // expected execute outputs from the opcode rules
    function automatic void expect_exec(input decode_info_t di, input word_t a, input word_t b,
                                        output word_t res, output logic tk, output word_t tgt);
        word_t rhs;
        rhs = di.use_imm ? di.imm : b;
        res = '0;
        tk  = 1'b0;
        case (di.op)
            OP_ADD:  res = a + rhs;
            OP_SUB:  res = a - rhs;
            OP_AND:  res = a & rhs;
            OP_OR:   res = a | rhs;
            OP_XOR:  res = a ^ rhs;
            OP_SLL:  res = a << rhs[4:0];
            OP_SRL:  res = a >> rhs[4:0];
            OP_SLT:  res = word_t'($signed(a) < $signed(rhs));
            OP_BEQ:  tk = (a == b);
            OP_BNE:  tk = (a != b);
            OP_BLT:  tk = ($signed(a) < $signed(b));
            OP_JAL: begin
                tk  = 1'b1;
                res = di.pc + 32'd4;
            end
            default: res = '0;
        endcase
        tgt = (di.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_JAL}) ? di.pc + di.imm : '0;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic timeout_hit(input string what);
        $display("timeout: %s", what);
        timed_out = 1'b1;
        errors++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        $display("test %s finished, %0d new errors", name, errors - err_before);
    endtask

    // results are taken at the edge they are consumed
    always @(posedge clk) begin
        word_t er;
        logic  et;
        word_t eg;
        if (!reset_i && result_valid_o && out_ready_i) begin
            results++;
            assert (exp_live[result_tag_o]) else begin
                $display("result with tag %0d was not expected", result_tag_o);
                errors++;
            end
            if (exp_live[result_tag_o]) begin
                expect_exec(exp_di[result_tag_o], exp_a[result_tag_o], exp_b[result_tag_o],
                            er, et, eg);
                check_word("result_o", er, result_o);
                check_word("taken_o", word_t'(et), word_t'(taken_o));
                check_word("target_o", eg, target_o);
                exp_live[result_tag_o] = 1'b0;
                pending--;
            end
        end
    end

    // --------------------------------------------------
    // dispatch and wait tasks
    // --------------------------------------------------
    task automatic dispatch(input int port, input alu_op_e op, input logic imm_sel,
                            input word_t a, input word_t b, input logic [1:0] rdy,
                            input rob_id_t tag_a, input rob_id_t tag_b);
        decode_info_t di;
        int           n;
        if (timed_out) begin
            return;
        end
        di.op      = op;
        di.use_imm = imm_sel;
        di.pc      = lcg_next() & 32'hFFFF_FFFC;
        di.imm     = lcg_next();
        di.dest_id = next_tag;
        choose_i                 = DISPATCH_CNT'(1) << port;
        disp_valid_i             = '0;
        disp_valid_i[port]       = 1'b1;
        disp_di_i[port]          = di;
        disp_src_ready_i[port]   = rdy;
        disp_src_tag_i[port][0]  = tag_a;
        disp_src_tag_i[port][1]  = tag_b;
        // waiting operands carry junk until their broadcast
        disp_src_data_i[port][0] = rdy[0] ? a : lcg_next();
        disp_src_data_i[port][1] = rdy[1] ? b : lcg_next();
        n = 0;
        while (!disp_ready_o && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!disp_ready_o) begin
            timeout_hit("dispatch was never accepted");
        end else begin
            next_cycle();
            exp_live[di.dest_id] = 1'b1;
            exp_di[di.dest_id]   = di;
            exp_a[di.dest_id]    = a;
            exp_b[di.dest_id]    = b;
            pending++;
            next_tag++;
        end
        disp_valid_i = '0;
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (pending != 0 && n < TIMEOUT && !timed_out) begin
            next_cycle();
            n++;
        end
        if (pending != 0 && !timed_out) begin
            timeout_hit($sformatf("%0d results missing in %s", pending, what));
        end
    endtask

    task automatic fill_queue(output int count);
        count = 0;
        while (disp_ready_o && count < 2 * IQ_SIZE && !timed_out) begin
            dispatch(count % 2, alu_op_e'(3'(lcg_next())), 1'(lcg_next()),
                     lcg_next(), lcg_next(), 2'b11, '0, '0);
            count++;
        end
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic alu_ready_ops();
        int e0;
        e0 = errors;
        // every alu op once with register operands, once with the immediate
        for (int i = 0; i < 16; i++) begin
            dispatch(i % 2, alu_op_e'(4'(i % 8)), 1'(i / 8),
                     lcg_next(), lcg_next(), 2'b11, '0, '0);
        end
        wait_drained("alu ops");
        end_test("alu_ready", e0);
    endtask

    task automatic branches_and_jal();
        int    e0;
        word_t a;
        word_t b;
        e0 = errors;
        // even steps use equal operands
        for (int i = 0; i < 8; i++) begin
            a = lcg_next();
            b = (i % 2 == 0) ? a : lcg_next();
            dispatch(i % 2, alu_op_e'(4'(8 + i / 2)), 1'(lcg_next()), a, b, 2'b11, '0, '0);
        end
        wait_drained("branches");
        end_test("branch_jal", e0);
    endtask

    task automatic cdb_capture();
        int    e0;
        word_t d;
        e0 = errors;
        d  = lcg_next();
        dispatch(0, OP_ADD, 1'b0, d, lcg_next(), 2'b10, 4'hA, '0);
        repeat (4) begin
            assert (!wkup_valid_o && !result_valid_o) else begin
                $display("instruction issued before its operand tag was broadcast");
                errors++;
            end
            next_cycle();
        end
        cdb_valid_i[1] = 1'b1;
        cdb_tag_i[1]   = 4'hA;
        cdb_data_i[1]  = d;
        next_cycle();
        cdb_valid_i = '0;
        wait_drained("cdb wakeup");
        // broadcast lands on the dispatch edge
        d = lcg_next();
        cdb_valid_i[0] = 1'b1;
        cdb_tag_i[0]   = 4'h5;
        cdb_data_i[0]  = d;
        dispatch(1, OP_SUB, 1'b0, lcg_next(), d, 2'b01, '0, 4'h5);
        cdb_valid_i = '0;
        wait_drained("same cycle capture");
        end_test("cdb_wakeup", e0);
    endtask

    task automatic stall_and_drain();
        int e0;
        int cnt;
        e0 = errors;
        out_ready_i = 1'b0;
        fill_queue(cnt);
        // one result held in the stage, the rest in the slots
        assert (cnt == IQ_SIZE + 1) else begin
            $display("queue accepted %0d instructions before filling", cnt);
            errors++;
        end
        check_word("disp_ready_o", '0, word_t'(disp_ready_o));
        repeat (3) next_cycle();
        out_ready_i = 1'b1;
        wait_drained("backpressure");
        end_test("backpressure", e0);
    endtask

    task automatic flush_full_queue();
        int e0;
        int cnt;
        e0 = errors;
        out_ready_i = 1'b0;
        fill_queue(cnt);
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        // flushed tags must never be reported
        for (int t = 0; t < TAG_CNT; t++) begin
            exp_live[t] = 1'b0;
        end
        pending = 0;
        check_word("disp_ready_o", 32'd1, word_t'(disp_ready_o));
        check_word("result_valid_o", '0, word_t'(result_valid_o));
        out_ready_i = 1'b1;
        repeat (6) next_cycle();
        dispatch(0, OP_XOR, 1'b1, lcg_next(), lcg_next(), 2'b11, '0, '0);
        wait_drained("after flush");
        end_test("flush", e0);
    endtask

    initial begin
        clk              = 1'b0;
        reset_i          = 1'b1;
        flush_i          = 1'b0;
        choose_i         = 2'b01;
        disp_valid_i     = '0;
        disp_di_i        = '0;
        disp_src_data_i  = '0;
        disp_src_tag_i   = '0;
        disp_src_ready_i = '0;
        cdb_valid_i      = '0;
        cdb_tag_i        = '0;
        cdb_data_i       = '0;
        out_ready_i      = 1'b1;
        pending          = 0;
        errors           = 0;
        results          = 0;
        tests_run        = 0;
        timed_out        = 1'b0;
        lcg_state        = 32'd36;
        next_tag         = '0;
        for (int t = 0; t < TAG_CNT; t++) begin
            exp_live[t] = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset_i = 1'b0;
        next_cycle();
        alu_ready_ops();
        branches_and_jal();
        cdb_capture();
        stall_and_drain();
        flush_full_queue();
        errors = errors + dut0.u_props.fails;
        $display("tests=%0d results=%0d errors=%0d", tests_run, results, errors);
        if (errors == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/alu_iq_pkg.sv
hw/iq_entry.sv
hw/alu_exec.sv
hw/alu_iq.sv
sim/alu_iq_properties.sv
sim/alu_iq_tb.sv
